/* verilog.f */
hdl/fir_pkg.sv
hdl/tap_sequencer.sv
hdl/mac_partition.sv
hdl/output_stage.sv
hdl/serial_fir.sv
test/serial_fir_assert.sv
test/serial_fir_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module serial_fir_tb \
		-f verilog.f -Mdir obj_dir
	./obj_dir/Vserial_fir_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/serial_fir_tb.sv */
`timescale 1ns/1ps

module serial_fir_tb;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 5;
  localparam int impulse_len  = 8;
  localparam int stream_len   = 48;
  localparam int stall_len    = 48;
  localparam int extreme_len  = 32;
  localparam int total_len    = impulse_len + stream_len + stall_len + extreme_len;
  localparam int watchdog_cycles = total_len * 5 * 4 + reset_cycles;   // 5 cycles per sample, x4

  // sfix16_En16, tap 0 first
  localparam logic signed [15:0] coeff_ref [8] = '{
    16'hDDBB, 16'hEA8E, 16'h33DB, 16'h6808,
    16'h6808, 16'h33DB, 16'hEA8E, 16'hDDBB
  };

  logic             clk;
  logic             reset;
  logic             in_valid;
  fir_pkg::sample_t in_data;
  logic             in_ready;
  logic             out_valid;
  fir_pkg::acc_t    out_data;
  logic             out_ready = 1'b0;

  longint        hist [8];                         // reference delay line, x[n] first
  fir_pkg::acc_t exp_q [$];                        // results still owed by the DUT
  fir_pkg::acc_t exp_head;
  int            exp_count;
  int            out_count = 0;
  int            errors = 0;
  int            tests_done = 0;
  int            low_pct = 0;                      // percent of cycles with out_ready low
  logic [31:0]   stim_rng;
  logic [31:0]   ready_rng = 32'd23;
  int            run_left;
  logic          run_high;

  serial_fir serial_fir_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  bind serial_fir serial_fir_assert protocol_chk (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .done      (done),
    .free      (free)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sum of coeff k times x[n-k], exact
  function automatic fir_pkg::acc_t reference_sum();
    longint sum;
    sum = 0;
    for (int k = 0; k < 8; k++) begin
      sum += hist[k] * longint'(coeff_ref[k]);
    end
    return fir_pkg::acc_t'(sum);
  endfunction

  function automatic int total_errors();
    return errors + serial_fir_inst.protocol_chk.fail_count;
  endfunction

  ////////////////////////////////////////
  // reference model and result queue
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 8; k++) begin
        hist[k] = 0;
      end
      exp_head  <= '0;
      exp_count <= 0;
    end else begin
      if (out_valid && out_ready) begin
        void'(exp_q.pop_front());
        out_count++;
      end
      if (in_valid && in_ready) begin
        for (int k = 7; k > 0; k--) begin
          hist[k] = hist[k-1];
        end
        hist[0] = longint'(in_data);
        exp_q.push_back(reference_sum());
      end
      exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_count <= exp_q.size();
    end
  end

  always @(posedge clk) begin
    ready_rng = xorshift(ready_rng);
    out_ready <= (ready_rng % 100) >= low_pct;
  end

  data_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready) |-> (out_data == exp_head))
    else begin
      $display("FAIL out_data: got %h, expected %h", $sampled(out_data), $sampled(exp_head));
      errors++;
    end

  count_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready) |-> (exp_count != 0))
    else begin
      $display("output transfer with no result outstanding");
      errors++;
    end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  function automatic fir_pkg::sample_t next_sample(input int kind, input int index);
    fir_pkg::sample_t value;
    case (kind)
      0: value = (index == 0) ? 16'sh7FFF : '0;    // impulse
      1: begin
        stim_rng = xorshift(stim_rng);
        value    = stim_rng[15:0];
      end
      default: begin                               // runs of full scale values
        if (run_left == 0) begin
          stim_rng = xorshift(stim_rng);
          run_left = 1 + int'(stim_rng % 4);
          run_high = ~run_high;
        end
        run_left--;
        value = run_high ? 16'sh7FFF : 16'sh8000;
      end
    endcase
    return value;
  endfunction

  task automatic send_sample(input fir_pkg::sample_t value);
    in_valid <= 1'b1;
    in_data  <= value;
    do begin
      @(posedge clk);
    end while (!in_ready);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    do begin
      @(posedge clk);
    end while (exp_count != 0);
  endtask

  task automatic run_test(input string name, input int kind, input int count,
                          input int stall_pct);
    int errors_before;
    int outputs_before;
    int gap;
    errors_before  = total_errors();
    outputs_before = out_count;
    low_pct <= stall_pct;
    for (int i = 0; i < count; i++) begin
      send_sample(next_sample(kind, i));
      stim_rng = xorshift(stim_rng);
      gap = (kind == 1) ? int'(stim_rng % 4) : 0;
      repeat (gap) @(posedge clk);
    end
    wait_drained();
    low_pct <= 0;
    tests_done++;
    $display("%s: %0d samples, %0d outputs, %0d errors", name, count,
             out_count - outputs_before, total_errors() - errors_before);
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    stim_rng = 32'd23;
    run_left = 0;
    run_high = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    run_test("impulse", 0, impulse_len, 0);
    run_test("stream", 1, stream_len, 0);
    run_test("backpressure", 1, stall_len, 60);
    run_test("extremes", 2, extreme_len, 30);
    @(negedge clk);                                // last edge's checks have settled
    $display("tests %0d, outputs %0d, errors %0d", tests_done, out_count, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* test/serial_fir_assert.sv */
`timescale 1ns/1ps

module serial_fir_assert (
  input logic             clk,
  input logic             reset,
  input logic             in_valid,
  input logic             in_ready,
  input fir_pkg::sample_t in_data,
  input logic             out_valid,
  input logic             out_ready,
  input fir_pkg::acc_t    out_data,
  input logic             done,
  input logic             free
);

  int   fail_count = 0;                            // summed into the testbench total
  int   since_accept;                              // cycles since the last input transfer
  logic seen_accept;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      since_accept <= 5;
      seen_accept  <= 1'b0;
    end else if (in_valid && in_ready) begin
      since_accept <= 1;
      seen_accept  <= 1'b1;
    end else if (since_accept < 5) begin
      since_accept <= since_accept + 1;
    end
  end

  reset_idle: assert property (@(posedge clk) reset |-> (in_ready && !out_valid))
    else begin
      $error("in_ready low or out_valid high during reset");
      fail_count++;
    end

  early_output: assert property (@(posedge clk) disable iff (reset)
    !seen_accept |-> !out_valid)
    else begin
      $error("out_valid raised before any sample was accepted");
      fail_count++;
    end

  accept_spacing: assert property (@(posedge clk) disable iff (reset)
    (in_valid && in_ready) |-> (since_accept >= 5))
    else begin
      $error("sample accepted less than five cycles after the previous one");
      fail_count++;
    end

  input_hold: assert property (@(posedge clk) disable iff (reset)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data)))
    else begin
      $error("in_valid dropped or in_data changed before the transfer");
      fail_count++;
    end

  output_hold: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
      $error("out_valid dropped or out_data changed before the transfer");
      fail_count++;
    end

  // a finished sum waiting on the output keeps the sequencer busy
  blocked_busy: assert property (@(posedge clk) disable iff (reset)
    (!free && !in_ready) |=> !in_ready)
    else begin
      $error("in_ready rose while a completed result was waiting");
      fail_count++;
    end

  // result loaded and sequencer idle right after the handoff
  done_handoff: assert property (@(posedge clk) disable iff (reset)
    done |=> (out_valid && in_ready))
    else begin
      $error("out_valid or in_ready not high in the cycle after done");
      fail_count++;
    end

endmodule

/* hdl/serial_fir.sv */
`timescale 1ns/1ps

module serial_fir #(
  parameter fir_pkg::coeff_set_t coeffs = fir_pkg::default_coeffs
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  fir_pkg::sample_t in_data,
  input  logic             out_ready,
  output logic             in_ready,
  output logic             out_valid,
  output fir_pkg::acc_t    out_data
);

  fir_pkg::mac_operand_t op_lo;                    // taps 0-3
  fir_pkg::mac_operand_t op_hi;                    // taps 4-7
  fir_pkg::mac_ctrl_t    ctrl;                     // shared by both partitions
  fir_pkg::acc_t         acc_lo;
  fir_pkg::acc_t         acc_hi;
  logic                  done;
  logic                  free;

  tap_sequencer #(
    .coeffs   (coeffs)
  ) seq (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_data  (in_data),
    .free     (free),
    .in_ready (in_ready),
    .op_lo    (op_lo),
    .op_hi    (op_hi),
    .ctrl     (ctrl),
    .done     (done)
  );

  mac_partition mac_lo (.clk(clk), .reset(reset), .op(op_lo), .ctrl(ctrl), .acc(acc_lo));
  mac_partition mac_hi (.clk(clk), .reset(reset), .op(op_hi), .ctrl(ctrl), .acc(acc_hi));

  output_stage out (
    .clk       (clk),
    .reset     (reset),
    .acc_lo    (acc_lo),
    .acc_hi    (acc_hi),
    .done      (done),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .free      (free)
  );

endmodule

/* hdl/output_stage.sv */
`timescale 1ns/1ps

module output_stage (
  input  logic          clk,
  input  logic          reset,
  input  fir_pkg::acc_t acc_lo,
  input  fir_pkg::acc_t acc_hi,
  input  logic          done,
  input  logic          out_ready,
  output logic          out_valid,
  output fir_pkg::acc_t out_data,
  output logic          free
);

  fir_pkg::acc_t total;                            // sfix33_En31, cannot overflow
  logic          taken;

  assign total = acc_lo + acc_hi;
  assign taken = out_valid & out_ready;

  // room for a new result: empty, or the current one leaves this cycle
  assign free = ~out_valid | out_ready;

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_data <= '0;
    end else if (done) begin
      out_data <= total;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (done) begin
      out_valid <= 1'b1;                           // done only comes while free is high
    end else if (taken) begin
      out_valid <= 1'b0;
    end
  end

endmodule

/* hdl/mac_partition.sv */
`timescale 1ns/1ps

module mac_partition (
  input  logic                  clk,
  input  logic                  reset,
  input  fir_pkg::mac_operand_t op,
  input  fir_pkg::mac_ctrl_t    ctrl,
  output fir_pkg::acc_t         acc
);

  localparam int ext_w = fir_pkg::acc_w - (fir_pkg::prod_w - 1);

  logic signed [fir_pkg::prod_w-1:0] product;      // sfix32_En31
  fir_pkg::acc_t                     prod_ext;     // sfix33_En31
  fir_pkg::acc_t                     acc_next;

  assign product = $signed(op.sample) * $signed(op.coeff);

  // top product bit is redundant for these operand ranges, drop it and re-extend
  assign prod_ext = {{ext_w{product[fir_pkg::prod_w-2]}}, product[fir_pkg::prod_w-2:0]};

  assign acc_next = ctrl.load ? prod_ext : acc + prod_ext;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc <= '0;
    end else if (ctrl.step) begin
      acc <= acc_next;                             // held while the sequencer waits
    end
  end

endmodule

/* hdl/tap_sequencer.sv */
`timescale 1ns/1ps

module tap_sequencer #(
  parameter fir_pkg::coeff_set_t coeffs = fir_pkg::default_coeffs
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  fir_pkg::sample_t      in_data,
  input  logic                  free,
  output logic                  in_ready,
  output fir_pkg::mac_operand_t op_lo,
  output fir_pkg::mac_operand_t op_hi,
  output fir_pkg::mac_ctrl_t    ctrl,
  output logic                  done
);

  fir_pkg::sample_t taps [fir_pkg::num_taps];      // x[n] .. x[n-7]
  fir_pkg::phase_t  phase;
  logic             busy;                          // sample accepted, not yet handed off
  logic             hold;                          // all phases done, waiting on output
  logic             accept;
  logic             last_phase;

  assign in_ready   = ~busy;
  assign accept     = in_valid & in_ready;
  assign last_phase = (phase == fir_pkg::phase_t'(fir_pkg::num_phases - 1));
  assign done       = hold & free;                 // single cycle, busy drops after it

  ////////////////////////////////////////
  // delay line
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < fir_pkg::num_taps; i++) begin
        taps[i] <= '0;
      end
    end else if (accept) begin
      taps[0] <= in_data;
      for (int i = 1; i < fir_pkg::num_taps; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // phase control
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy  <= 1'b0;
      hold  <= 1'b0;
      phase <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      hold  <= 1'b0;
      phase <= '0;
    end else if (ctrl.step) begin
      phase <= phase + 1'b1;                       // wraps back to 0 after the last phase
      if (last_phase) begin
        hold <= 1'b1;
      end
    end else if (done) begin
      busy <= 1'b0;
      hold <= 1'b0;
    end
  end

  always_comb begin
    ctrl.step = busy & ~hold;
    ctrl.load = busy & ~hold & (phase == '0);
  end

  // operand select, lo half takes taps 0-3 and hi half taps 4-7
  always_comb begin
    op_lo.sample = taps[phase];
    op_lo.coeff  = coeffs[phase];
    op_hi.sample = taps[fir_pkg::num_phases + phase];
    op_hi.coeff  = coeffs[fir_pkg::num_phases + phase];
  end

endmodule

/* hdl/fir_pkg.sv */
package fir_pkg;

  ////////////////////////////////////////
  // filter geometry
  ////////////////////////////////////////
  localparam int num_taps   = 8;
  localparam int num_phases = 4;                   // taps per partition

  localparam int sample_w = 16;
  localparam int coeff_w  = 16;
  localparam int prod_w   = sample_w + coeff_w;    // full signed product
  localparam int acc_w    = 33;

  ////////////////////////////////////////
  // fixed-point words
  ////////////////////////////////////////
  typedef logic signed [sample_w-1:0] sample_t;    // sfix16_En15
  typedef logic signed [coeff_w-1:0]  coeff_t;     // sfix16_En16
  typedef logic signed [acc_w-1:0]    acc_t;       // sfix33_En31
  typedef logic [1:0]                 phase_t;

  typedef coeff_t coeff_set_t [num_taps];

  // symmetric low-pass set, tap 0 first
  localparam coeff_set_t default_coeffs = '{
    16'hDDBB,
    16'hEA8E,
    16'h33DB,
    16'h6808,
    16'h6808,
    16'h33DB,
    16'hEA8E,
    16'hDDBB
  };

  ////////////////////////////////////////
  // sequencer to MAC bundles
  ////////////////////////////////////////
  typedef struct packed {
    sample_t sample;                               // delayed input for this phase
    coeff_t  coeff;                                // matching coefficient
  } mac_operand_t;

  typedef struct packed {
    logic load;                                    // first phase, restart the sum
    logic step;                                    // accumulator enable
  } mac_ctrl_t;

endpackage
